// ==== udp_mux_pkg.sv ====
// shared source count and widths, source index and vector types, header and payload beat structs
`default_nettype none

package udp_mux_pkg;

    // number of multiplexed sources
    localparam int source_count = 4;
    localparam int source_idx_width = $clog2(source_count);

    // payload is one byte per beat
    localparam int data_width = 8;

    typedef logic [source_idx_width-1:0] source_idx_t;

    // one bit per source
    typedef logic [source_count-1:0] source_vec_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        logic                  user;
    } payload_beat_t;

    // ethernet, ipv4 and udp header fields, in wire order
    typedef struct packed {
        // ethernet
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        // ipv4
        logic [3:0]  ip_version;
        logic [3:0]  ip_ihl;
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [15:0] ip_length;
        logic [15:0] ip_identification;
        logic [2:0]  ip_flags;
        logic [12:0] ip_fragment_offset;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_header_checksum;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        // udp
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } udp_hdr_t;

endpackage

`default_nettype wire

// ==== udp_rr_arbiter.sv ====
// round-robin arbiter holding its one-hot grant and encoded index until the frame ends
`default_nettype none

module udp_rr_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_mux_pkg::source_vec_t hdr_valid,
    input  logic                     frame_done,
    output udp_mux_pkg::source_vec_t grant,
    output logic                     grant_valid,
    output udp_mux_pkg::source_idx_t grant_idx
);

    udp_mux_pkg::source_vec_t request;
    udp_mux_pkg::source_idx_t winner_idx;
    logic                     winner_found;

    // the granted source is never a candidate again while it holds the grant
    assign request = hdr_valid & ~grant;

    // search starts one past the last winner and wraps around
    // grant_idx keeps the last winner after release, so it doubles as the pointer
    always_comb begin
        udp_mux_pkg::source_idx_t cand;

        winner_idx   = grant_idx;
        winner_found = 1'b0;
        cand         = grant_idx;
        for (int i = 1; i <= udp_mux_pkg::source_count; i++) begin
            cand = grant_idx + udp_mux_pkg::source_idx_t'(i);
            if (!winner_found && request[cand]) begin
                winner_idx   = cand;
                winner_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            // first search after reset begins at source 0
            grant_idx   <= udp_mux_pkg::source_idx_t'(udp_mux_pkg::source_count - 1);
        end else if (grant_valid) begin
            // block until the granted frame is acknowledged by its last beat
            if (frame_done) begin
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end else if (winner_found) begin
            grant       <= udp_mux_pkg::source_vec_t'(1) << winner_idx;
            grant_valid <= 1'b1;
            grant_idx   <= winner_idx;
        end
    end

endmodule

`default_nettype wire

// ==== udp_hdr_capture.sv ====
// frame-open tracking, output header register and per-source header ready pulse
`default_nettype none

module udp_hdr_capture (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_mux_pkg::udp_hdr_t    hdr_in [udp_mux_pkg::source_count],
    input  udp_mux_pkg::source_vec_t grant,
    input  logic                     grant_valid,
    input  udp_mux_pkg::source_idx_t grant_idx,
    input  logic                     frame_done,
    output udp_mux_pkg::source_vec_t hdr_ready,
    output udp_mux_pkg::udp_hdr_t    m_hdr,
    output logic                     m_hdr_valid,
    input  logic                     m_hdr_ready
);

    logic frame_open;
    logic hdr_slot_free;
    logic frame_start;

    // output register empty, or its header leaves this cycle
    assign hdr_slot_free = !m_hdr_valid || m_hdr_ready;

    // a new grant starts a frame once there is room for its header
    // the source must not hand over its last beat before this header is accepted,
    // otherwise the grant could end with the header still waiting
    assign frame_start = !frame_open && grant_valid && hdr_slot_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open  <= 1'b0;
            hdr_ready   <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            // single-cycle ready towards the granted source
            if (frame_start) begin
                hdr_ready <= grant;
            end else begin
                hdr_ready <= '0;
            end

            if (frame_start) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end

            // end of frame wins, the grant drops on this same edge
            if (frame_done) begin
                frame_open <= 1'b0;
            end else if (frame_start) begin
                frame_open <= 1'b1;
            end
        end
    end

    // header payload register, loaded only at frame start
    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_hdr <= hdr_in[grant_idx];
        end
    end

endmodule

`default_nettype wire

// ==== udp_payload_path.sv ====
// granted-source payload select, source ready steering, end-of-frame strobe and output skid buffer
`default_nettype none

module udp_payload_path (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_mux_pkg::payload_beat_t payload_in [udp_mux_pkg::source_count],
    input  udp_mux_pkg::source_vec_t   payload_valid,
    output udp_mux_pkg::source_vec_t   payload_ready,
    input  logic                       grant_valid,
    input  udp_mux_pkg::source_idx_t   grant_idx,
    output logic                       frame_done,
    output udp_mux_pkg::payload_beat_t m_payload,
    output logic                       m_payload_valid,
    input  logic                       m_payload_ready
);

    udp_mux_pkg::payload_beat_t sel_beat;
    logic                       sel_valid;

    // registered ready into the skid buffer and its early version
    logic                       ready_int;
    logic                       ready_early;
    logic                       int_valid;

    udp_mux_pkg::payload_beat_t temp_beat;
    logic                       temp_valid;

    logic                       out_valid_next;
    logic                       temp_valid_next;
    logic                       store_int_to_out;
    logic                       store_int_to_temp;
    logic                       store_temp_to_out;

    // mux for the granted source
    assign sel_beat  = payload_in[grant_idx];
    assign sel_valid = payload_valid[grant_idx];

    // only the granted source sees ready
    assign payload_ready = (ready_int && grant_valid) ?
                           (udp_mux_pkg::source_vec_t'(1) << grant_idx) : '0;

    // beat accepted from the granted source this cycle
    assign int_valid  = sel_valid && ready_int && grant_valid;
    assign frame_done = int_valid && sel_beat.last;

    // ready next cycle unless the temp register would have to take a beat and is full
    assign ready_early = m_payload_ready ||
                         (!temp_valid && (!m_payload_valid || !int_valid));

    always_comb begin
        out_valid_next    = m_payload_valid;
        temp_valid_next   = temp_valid;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_int) begin
            if (m_payload_ready || !m_payload_valid) begin
                // output free, beat goes straight out
                out_valid_next   = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled, park beat in temp
                temp_valid_next   = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (m_payload_ready) begin
            // input held off, drain temp into output
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_valid <= 1'b0;
            temp_valid      <= 1'b0;
            ready_int       <= 1'b0;
        end else begin
            m_payload_valid <= out_valid_next;
            temp_valid      <= temp_valid_next;
            ready_int       <= ready_early;
        end
    end

    // beat registers
    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            m_payload <= sel_beat;
        end else if (store_temp_to_out) begin
            m_payload <= temp_beat;
        end

        if (store_int_to_temp) begin
            temp_beat <= sel_beat;
        end
    end

endmodule

`default_nettype wire

// ==== udp_arb_mux.sv ====
// top level: four-source UDP frame multiplexer with round-robin arbitration
`default_nettype none

// sources send a frame's last payload beat no earlier than the cycle
// its header is accepted (hdr_valid and hdr_ready both high)
module udp_arb_mux (
    input  logic                       clk,
    input  logic                       rst,

    // per-source header and payload
    input  udp_mux_pkg::source_vec_t   hdr_valid,
    output udp_mux_pkg::source_vec_t   hdr_ready,
    input  udp_mux_pkg::udp_hdr_t      hdr [udp_mux_pkg::source_count],
    input  udp_mux_pkg::source_vec_t   payload_valid,
    output udp_mux_pkg::source_vec_t   payload_ready,
    input  udp_mux_pkg::payload_beat_t payload [udp_mux_pkg::source_count],

    // multiplexed output
    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output udp_mux_pkg::udp_hdr_t      m_hdr,
    output logic                       m_payload_valid,
    input  logic                       m_payload_ready,
    output udp_mux_pkg::payload_beat_t m_payload
);

    udp_mux_pkg::source_vec_t grant;
    logic                     grant_valid;
    udp_mux_pkg::source_idx_t grant_idx;

    // last beat of the granted frame accepted
    logic                     frame_done;

    udp_rr_arbiter arb_inst (
        .clk         (clk),
        .rst         (rst),
        .hdr_valid   (hdr_valid),
        .frame_done  (frame_done),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    udp_hdr_capture hdr_inst (
        .clk         (clk),
        .rst         (rst),
        .hdr_in      (hdr),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .frame_done  (frame_done),
        .hdr_ready   (hdr_ready),
        .m_hdr       (m_hdr),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready)
    );

    udp_payload_path payload_inst (
        .clk             (clk),
        .rst             (rst),
        .payload_in      (payload),
        .payload_valid   (payload_valid),
        .payload_ready   (payload_ready),
        .grant_valid     (grant_valid),
        .grant_idx       (grant_idx),
        .frame_done      (frame_done),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

endmodule

`default_nettype wire

// ==== udp_arb_mux_sva.sv ====
// concurrent assertions on source readies and output stability, bound to the multiplexer top
`default_nettype none

module udp_arb_mux_sva (
    input logic                       clk,
    input logic                       rst,
    input udp_mux_pkg::source_vec_t   hdr_valid,
    input udp_mux_pkg::source_vec_t   hdr_ready,
    input udp_mux_pkg::source_vec_t   payload_ready,
    input udp_mux_pkg::source_vec_t   grant,
    input logic                       m_hdr_valid,
    input logic                       m_hdr_ready,
    input udp_mux_pkg::udp_hdr_t      m_hdr,
    input logic                       m_payload_valid,
    input logic                       m_payload_ready,
    input udp_mux_pkg::payload_beat_t m_payload
);

    // header ready only for one source that offers a header
    hdr_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hdr_ready) && ((hdr_ready & ~hdr_valid) == '0))
        else $error("header ready given to several sources or to one without a header");

    // payload ready only for the source holding the grant
    payload_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(payload_ready) && ((payload_ready & ~grant) == '0))
        else $error("payload ready given to several sources or to one without the grant");

    // stalled outputs keep valid and data
    m_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_hdr))
        else $error("output header changed while stalled");

    m_payload_stable: assert property (@(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload))
        else $error("output payload beat changed while stalled");

endmodule

`default_nettype wire

// ==== tb_udp_arb_mux.sv ====
// testbench with LFSR stimulus, per-source model queues, checks and watchdog for the UDP frame mux
`default_nettype none

module tb_udp_arb_mux;

    localparam int clk_period        = 4;
    localparam int frames_per_source = 10;
    // leading frames per source offered without header pauses
    localparam int cyclic_frames     = 4;
    localparam int max_len           = 8;
    localparam int cycles_per_beat   = 4;
    localparam int margin            = 4;
    localparam int total_frames      = frames_per_source * udp_mux_pkg::source_count;
    localparam int watchdog_cycles   = total_frames * max_len * cycles_per_beat * margin;

    logic                       clk;
    logic                       rst;
    udp_mux_pkg::source_vec_t   hdr_valid;
    udp_mux_pkg::source_vec_t   hdr_ready;
    udp_mux_pkg::udp_hdr_t      hdr [udp_mux_pkg::source_count];
    udp_mux_pkg::source_vec_t   payload_valid;
    udp_mux_pkg::source_vec_t   payload_ready;
    udp_mux_pkg::payload_beat_t payload [udp_mux_pkg::source_count];
    logic                       m_hdr_valid;
    logic                       m_hdr_ready;
    udp_mux_pkg::udp_hdr_t      m_hdr;
    logic                       m_payload_valid;
    logic                       m_payload_ready;
    udp_mux_pkg::payload_beat_t m_payload;

    logic [31:0]                lfsr_state;

    // frames still to be driven, per source
    udp_mux_pkg::udp_hdr_t      drv_hdr_q [udp_mux_pkg::source_count][$];
    udp_mux_pkg::payload_beat_t drv_beat_q [udp_mux_pkg::source_count][$];

    // reference model
    udp_mux_pkg::udp_hdr_t      exp_hdr_q [udp_mux_pkg::source_count][$];
    udp_mux_pkg::payload_beat_t exp_beat_q [udp_mux_pkg::source_count][$];
    // sources of taken headers whose payload is still incomplete
    int                         hdr_src_q [$];
    udp_mux_pkg::payload_beat_t out_beat_q [$];

    int                         hdr_acc [udp_mux_pkg::source_count];
    int                         pay_frame [udp_mux_pkg::source_count];
    int                         total_beats;
    int                         frames_sent;
    int                         beats_sent;
    int                         hdr_recv;
    int                         beats_recv;
    int                         frames_recv;
    udp_mux_pkg::source_idx_t   prev_src;

    always #(clk_period / 2) clk = ~clk;

    udp_arb_mux uut (
        .clk             (clk),
        .rst             (rst),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .hdr             (hdr),
        .payload_valid   (payload_valid),
        .payload_ready   (payload_ready),
        .payload         (payload),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload       (m_payload)
    );

    bind udp_arb_mux udp_arb_mux_sva sva_inst (
        .clk             (clk),
        .rst             (rst),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .payload_ready   (payload_ready),
        .grant           (grant),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload       (m_payload)
    );

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;

        r = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hdr(input string name, input udp_mux_pkg::udp_hdr_t got,
                             input udp_mux_pkg::udp_hdr_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_beat(input string name, input udp_mux_pkg::payload_beat_t got,
                              input udp_mux_pkg::payload_beat_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input udp_mux_pkg::source_idx_t got,
                             input udp_mux_pkg::source_idx_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vec(input string name, input udp_mux_pkg::source_vec_t got,
                             input udp_mux_pkg::source_vec_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // random headers and payload copied into drive and model queues
    task automatic make_frames();
        logic [$bits(udp_mux_pkg::udp_hdr_t)-1:0] bits;
        logic [31:0]                              r;
        udp_mux_pkg::udp_hdr_t                    h;
        udp_mux_pkg::payload_beat_t               b;
        int                                       len;

        total_beats = 0;
        for (int s = 0; s < udp_mux_pkg::source_count; s++) begin
            for (int f = 0; f < frames_per_source; f++) begin
                for (int k = 0; k < $bits(bits); k++) begin
                    r       = rand_bits(1);
                    bits[k] = r[0];
                end
                h = bits;
                // source index and frame count make each frame traceable
                h.udp_source_port = {8'(s), 8'(f)};
                drv_hdr_q[s].push_back(h);
                exp_hdr_q[s].push_back(h);
                r   = rand_bits(3);
                len = int'(r[2:0]) + 1;
                for (int k = 0; k < len; k++) begin
                    r      = rand_bits(9);
                    b.data = r[8:1];
                    b.user = r[0];
                    b.last = (k == len - 1);
                    drv_beat_q[s].push_back(b);
                    exp_beat_q[s].push_back(b);
                end
                total_beats += len;
            end
        end
    endtask

    always @(posedge clk) begin : drive
        udp_mux_pkg::source_vec_t   hv;
        udp_mux_pkg::source_vec_t   pv;
        udp_mux_pkg::payload_beat_t nb;
        logic [31:0]                r;
        logic                       go;

        if (!rst) begin
            hv = hdr_valid;
            pv = payload_valid;
            for (int s = 0; s < udp_mux_pkg::source_count; s++) begin
                if (hv[s] && hdr_ready[s]) begin
                    void'(drv_hdr_q[s].pop_front());
                    hdr_acc[s]++;
                    frames_sent++;
                    hv[s] = 1'b0;
                end
                r  = rand_bits(2);
                go = (hdr_acc[s] < cyclic_frames) || (r[1:0] != 2'b00);
                if (!hv[s] && drv_hdr_q[s].size() > 0 && go) begin
                    hv[s] = 1'b1;
                    hdr[s] <= drv_hdr_q[s][0];
                end

                if (pv[s] && payload_ready[s]) begin
                    if (drv_beat_q[s][0].last) begin
                        pay_frame[s]++;
                    end
                    void'(drv_beat_q[s].pop_front());
                    beats_sent++;
                    pv[s] = 1'b0;
                end
                r  = rand_bits(2);
                go = (r[1:0] != 2'b00);
                if (!pv[s] && drv_beat_q[s].size() > 0 && go) begin
                    nb = drv_beat_q[s][0];
                    // last beat waits for its own header to be accepted
                    if (!nb.last || hdr_acc[s] > pay_frame[s]) begin
                        pv[s] = 1'b1;
                        payload[s] <= nb;
                    end
                end
            end
            hdr_valid     <= hv;
            payload_valid <= pv;
            r = rand_bits(2);
            m_hdr_ready     <= r[0];
            m_payload_ready <= r[1];
        end
    end

    always @(posedge clk) begin : monitor
        int                         src;
        udp_mux_pkg::payload_beat_t ob;

        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                src = int'(m_hdr.udp_source_port[15:8]);
                if (src >= udp_mux_pkg::source_count || exp_hdr_q[src].size() == 0) begin
                    $display("Error at time %0t: output header names no pending source",
                             $time);
                    abort_run();
                end else begin
                    check_hdr("m_hdr", m_hdr, exp_hdr_q[src][0]);
                    void'(exp_hdr_q[src].pop_front());
                    // every source has a frame waiting in the first rounds
                    if (hdr_recv > 0 &&
                        hdr_recv < cyclic_frames * udp_mux_pkg::source_count) begin
                        check_idx("m_hdr source", udp_mux_pkg::source_idx_t'(src),
                                  udp_mux_pkg::source_idx_t'((int'(prev_src) + 1) %
                                                             udp_mux_pkg::source_count));
                    end
                    prev_src = udp_mux_pkg::source_idx_t'(src);
                    hdr_src_q.push_back(src);
                    hdr_recv++;
                end
            end

            if (m_payload_valid && m_payload_ready) begin
                out_beat_q.push_back(m_payload);
                beats_recv++;
                if (m_payload.last) begin
                    frames_recv++;
                end
            end

            // beats are matched once the header of their frame is out
            while (hdr_src_q.size() > 0 && out_beat_q.size() > 0) begin
                ob  = out_beat_q.pop_front();
                src = hdr_src_q[0];
                if (exp_beat_q[src].size() == 0) begin
                    $display("Error at time %0t: payload beat beyond the frames of source %0d",
                             $time, src);
                    abort_run();
                end else begin
                    check_beat("m_payload", ob, exp_beat_q[src][0]);
                    void'(exp_beat_q[src].pop_front());
                    if (ob.last) begin
                        void'(hdr_src_q.pop_front());
                    end
                end
            end
        end
    end

    initial begin : main
        logic ok;

        lfsr_state = 32'h13f9;
        clk        = 1'b0;
        rst             <= 1'b1;
        hdr_valid       <= '0;
        payload_valid   <= '0;
        m_hdr_ready     <= 1'b0;
        m_payload_ready <= 1'b0;
        for (int s = 0; s < udp_mux_pkg::source_count; s++) begin
            hdr[s]       <= '0;
            payload[s]   <= '0;
            hdr_acc[s]   = 0;
            pay_frame[s] = 0;
        end
        frames_sent = 0;
        beats_sent  = 0;
        hdr_recv    = 0;
        beats_recv  = 0;
        frames_recv = 0;
        prev_src    = '0;
        make_frames();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // idle outputs before any source offers data
        @(negedge clk);
        check_bit("m_hdr_valid", m_hdr_valid, 1'b0);
        check_bit("m_payload_valid", m_payload_valid, 1'b0);
        check_vec("hdr_ready", hdr_ready, '0);
        check_vec("payload_ready", payload_ready, '0);

        while (hdr_recv < total_frames || frames_recv < total_frames) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        ok = (frames_sent == total_frames) && (hdr_recv == total_frames) &&
             (frames_recv == total_frames) && (beats_sent == total_beats) &&
             (beats_recv == total_beats) && (hdr_src_q.size() == 0) && (out_beat_q.size() == 0);
        for (int s = 0; s < udp_mux_pkg::source_count; s++) begin
            ok = ok && (exp_hdr_q[s].size() == 0) && (exp_beat_q[s].size() == 0);
        end
        if (!ok) begin
            $display("Error at time %0t: frames or beats lost or duplicated", $time);
            $display("%0d frames and %0d beats sent, %0d headers and %0d beats out",
                     frames_sent, beats_sent, hdr_recv, beats_recv);
            abort_run();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("Timeout: not all frames reached the output within %0d cycles", watchdog_cycles);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== udp_arb_mux.f ====
udp_mux_pkg.sv
udp_rr_arbiter.sv
udp_hdr_capture.sv
udp_payload_path.sv
udp_arb_mux.sv
udp_arb_mux_sva.sv
tb_udp_arb_mux.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_udp_arb_mux \
    -f udp_arb_mux.f -o tb_udp_arb_mux > build.log 2>&1 \
    && ./obj_dir/tb_udp_arb_mux > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat build.log sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log 2>/dev/null && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
